/* design/npc_pkg.sv */
// NPC shared package with widths, opcodes, CSR map and the decoded control bundle.
package npc_pkg;

  localparam int XLEN = 64;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [31:0]     inst_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [11:0]     csr_addr_t;

  localparam xlen_t RESET_PC = 64'h0000_0000_8000_0000;

  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MTVEC   = 12'h305;
  localparam csr_addr_t CSR_MEPC    = 12'h341;
  localparam csr_addr_t CSR_MCAUSE  = 12'h342;

  localparam xlen_t CAUSE_ECALL_M = 64'd11;

  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_OP     = 7'b0110011;
  localparam logic [6:0] OP_IMM32  = 7'b0011011;
  localparam logic [6:0] OP_OP32   = 7'b0111011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL
  } alu_op_e;

  typedef enum logic {A_RS1, A_PC} alu_a_e;

  typedef enum logic [1:0] {B_RS2, B_IMM, B_FOUR} alu_b_e;

  typedef enum logic [3:0] {
    BR_NONE, BR_JAL, BR_JALR, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
  } branch_e;

  typedef enum logic [2:0] {MEM_B, MEM_BU, MEM_W, MEM_WU, MEM_D} mem_op_e;

  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_CSR} wb_sel_e;

  typedef struct packed {
    alu_op_e alu_op;
    alu_a_e  alu_a;
    alu_b_e  alu_b;
    logic    word_cut;
    branch_e branch;
    logic    mem_rd;
    logic    mem_wr;
    mem_op_e mem_op;
    logic    reg_wr;
    wb_sel_e wb_sel;
    logic    csr_wr;
    logic    csr_set;  // csrrs, old value ORed with source.
    logic    sel_zimm;
    logic    ecall;
    logic    mret;
    logic    invalid;  // Ebreak or unknown encoding.
  } ctrl_t;

endpackage

/* design/npc_ifu.sv */
// NPC fetch unit holding the program counter and the halt latch.
module npc_ifu (
  input  logic          i_clk,
  input  logic          i_arst_n,
  input  npc_pkg::xlen_t i_nextpc,
  input  logic          i_stop,
  output npc_pkg::xlen_t o_pc,
  output logic          o_halted
);

  npc_pkg::xlen_t pc_q;
  logic           halted_q;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pc_q     <= npc_pkg::RESET_PC;
      halted_q <= 1'b0;
    end else begin
      if (i_stop) begin
        halted_q <= 1'b1;
      end
      // PC stays on the stopping instruction.
      if (!halted_q && !i_stop) begin
        pc_q <= i_nextpc;
      end
    end
  end

  assign o_pc     = pc_q;
  assign o_halted = halted_q;

endmodule

/* design/npc_idu.sv */
// NPC decode unit with control decode, immediates and the general register file.
module npc_idu (
  input  logic                i_clk,
  input  logic                i_arst_n,
  input  npc_pkg::inst_t      i_inst,
  input  logic                i_halted,
  input  npc_pkg::xlen_t      i_wb_data,
  output npc_pkg::ctrl_t      o_ctrl,
  output npc_pkg::xlen_t      o_rs1data,
  output npc_pkg::xlen_t      o_rs2data,
  output npc_pkg::xlen_t      o_imm,
  output npc_pkg::xlen_t      o_zimm,
  output npc_pkg::csr_addr_t  o_csr_addr
);

  logic [6:0]        opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  npc_pkg::reg_idx_t rs1_idx;
  npc_pkg::reg_idx_t rs2_idx;
  npc_pkg::reg_idx_t rd_idx;
  npc_pkg::ctrl_t    c;
  logic              bad;
  npc_pkg::xlen_t    regs [1:31];

  assign opcode  = i_inst[6:0];
  assign funct3  = i_inst[14:12];
  assign funct7  = i_inst[31:25];
  assign rd_idx  = i_inst[11:7];
  assign rs2_idx = i_inst[24:20];
  assign rs1_idx = (opcode == npc_pkg::OP_LUI) ? '0 : i_inst[19:15]; // lui adds to x0.

  always_comb begin
    bad = 1'b0;
    c   = '0;
    case (opcode)
      npc_pkg::OP_LUI: begin
        c.alu_b  = npc_pkg::B_IMM;
        c.reg_wr = 1'b1;
      end
      npc_pkg::OP_AUIPC: begin
        c.alu_a  = npc_pkg::A_PC;
        c.alu_b  = npc_pkg::B_IMM;
        c.reg_wr = 1'b1;
      end
      npc_pkg::OP_JAL, npc_pkg::OP_JALR: begin
        c.alu_a  = npc_pkg::A_PC;   // Link value pc + 4.
        c.alu_b  = npc_pkg::B_FOUR;
        c.reg_wr = 1'b1;
        c.branch = (opcode == npc_pkg::OP_JAL) ? npc_pkg::BR_JAL : npc_pkg::BR_JALR;
        bad      = (opcode == npc_pkg::OP_JALR) && (funct3 != 3'd0);
      end
      npc_pkg::OP_BRANCH: begin
        case (funct3)
          3'd0: c.branch = npc_pkg::BR_EQ;
          3'd1: c.branch = npc_pkg::BR_NE;
          3'd4: c.branch = npc_pkg::BR_LT;
          3'd5: c.branch = npc_pkg::BR_GE;
          3'd6: c.branch = npc_pkg::BR_LTU;
          3'd7: c.branch = npc_pkg::BR_GEU;
          default: bad = 1'b1;
        endcase
      end
      npc_pkg::OP_LOAD: begin
        c.alu_b  = npc_pkg::B_IMM;
        c.mem_rd = 1'b1;
        c.reg_wr = 1'b1;
        c.wb_sel = npc_pkg::WB_MEM;
        case (funct3)
          3'd0: c.mem_op = npc_pkg::MEM_B;
          3'd4: c.mem_op = npc_pkg::MEM_BU;
          3'd2: c.mem_op = npc_pkg::MEM_W;
          3'd6: c.mem_op = npc_pkg::MEM_WU;
          3'd3: c.mem_op = npc_pkg::MEM_D;
          default: bad = 1'b1;
        endcase
      end
      npc_pkg::OP_STORE: begin
        c.alu_b  = npc_pkg::B_IMM;
        c.mem_wr = 1'b1;
        case (funct3)
          3'd0: c.mem_op = npc_pkg::MEM_B;
          3'd2: c.mem_op = npc_pkg::MEM_W;
          3'd3: c.mem_op = npc_pkg::MEM_D;
          default: bad = 1'b1;
        endcase
      end
      npc_pkg::OP_IMM: begin
        c.alu_b  = npc_pkg::B_IMM;
        c.reg_wr = 1'b1;
        case (funct3)
          3'd0: c.alu_op = npc_pkg::ALU_ADD;
          3'd2: c.alu_op = npc_pkg::ALU_SLT;
          3'd4: c.alu_op = npc_pkg::ALU_XOR;
          3'd6: c.alu_op = npc_pkg::ALU_OR;
          3'd7: c.alu_op = npc_pkg::ALU_AND;
          3'd1: begin
            c.alu_op = npc_pkg::ALU_SLL;
            bad      = (i_inst[31:26] != 6'd0);
          end
          3'd5: begin
            c.alu_op = npc_pkg::ALU_SRL;
            bad      = (i_inst[31:26] != 6'd0); // No srai.
          end
          default: bad = 1'b1;
        endcase
      end
      npc_pkg::OP_OP: begin
        c.reg_wr = 1'b1;
        case ({funct7, funct3})
          10'h000: c.alu_op = npc_pkg::ALU_ADD;
          10'h100: c.alu_op = npc_pkg::ALU_SUB;
          10'h007: c.alu_op = npc_pkg::ALU_AND;
          10'h006: c.alu_op = npc_pkg::ALU_OR;
          10'h004: c.alu_op = npc_pkg::ALU_XOR;
          10'h002: c.alu_op = npc_pkg::ALU_SLT;
          10'h003: c.alu_op = npc_pkg::ALU_SLTU;
          10'h001: c.alu_op = npc_pkg::ALU_SLL;
          10'h005: c.alu_op = npc_pkg::ALU_SRL;
          default: bad = 1'b1;
        endcase
      end
      npc_pkg::OP_IMM32: begin
        c.alu_b    = npc_pkg::B_IMM;
        c.word_cut = 1'b1;
        c.reg_wr   = 1'b1;
        bad        = (funct3 != 3'd0);
      end
      npc_pkg::OP_OP32: begin
        c.word_cut = 1'b1;
        c.reg_wr   = 1'b1;
        case ({funct7, funct3})
          10'h000: c.alu_op = npc_pkg::ALU_ADD;
          10'h100: c.alu_op = npc_pkg::ALU_SUB;
          default: bad = 1'b1;
        endcase
      end
      npc_pkg::OP_SYSTEM: begin
        case (funct3)
          3'd0: begin
            c.ecall = (i_inst == 32'h0000_0073);
            c.mret  = (i_inst == 32'h3020_0073);
            bad     = !(c.ecall || c.mret); // Ebreak lands here.
          end
          3'd1, 3'd2, 3'd5: begin
            c.csr_wr   = 1'b1;
            c.reg_wr   = 1'b1;
            c.wb_sel   = npc_pkg::WB_CSR;
            c.csr_set  = (funct3 == 3'd2);
            c.sel_zimm = (funct3 == 3'd5);
          end
          default: bad = 1'b1;
        endcase
      end
      default: bad = 1'b1;
    endcase
    if (bad) begin
      c         = '0;
      c.invalid = 1'b1;
    end
  end

  always_comb begin
    case (opcode)
      npc_pkg::OP_STORE:
        o_imm = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
      npc_pkg::OP_BRANCH:
        o_imm = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
      npc_pkg::OP_LUI, npc_pkg::OP_AUIPC:
        o_imm = {{32{i_inst[31]}}, i_inst[31:12], 12'd0};
      npc_pkg::OP_JAL:
        o_imm = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
      default:
        o_imm = {{52{i_inst[31]}}, i_inst[31:20]};
    endcase
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (c.reg_wr && !i_halted && (rd_idx != '0)) begin
      regs[rd_idx] <= i_wb_data;
    end
  end

  assign o_rs1data  = (rs1_idx == '0) ? '0 : regs[rs1_idx];
  assign o_rs2data  = (rs2_idx == '0) ? '0 : regs[rs2_idx];
  assign o_zimm     = {59'd0, i_inst[19:15]};
  assign o_csr_addr = i_inst[31:20];
  assign o_ctrl     = c;

endmodule

/* design/npc_exu.sv */
// NPC execute unit with the ALU, branch decision, next PC and writeback select.
module npc_exu (
  input  npc_pkg::ctrl_t i_ctrl,
  input  npc_pkg::xlen_t i_pc,
  input  npc_pkg::xlen_t i_rs1,
  input  npc_pkg::xlen_t i_rs2,
  input  npc_pkg::xlen_t i_imm,
  input  npc_pkg::xlen_t i_zimm,
  input  npc_pkg::xlen_t i_load_data,
  input  npc_pkg::xlen_t i_csr_rdata,
  input  logic           i_csr_redirect,
  input  npc_pkg::xlen_t i_csr_target,
  output npc_pkg::xlen_t o_alu_result,
  output npc_pkg::xlen_t o_nextpc,
  output npc_pkg::xlen_t o_wb_data,
  output npc_pkg::xlen_t o_csr_wdata
);

  npc_pkg::xlen_t op_a;
  npc_pkg::xlen_t op_b;
  npc_pkg::xlen_t alu_raw;
  npc_pkg::xlen_t jalr_target;
  npc_pkg::xlen_t csr_src;
  logic           taken;

  assign op_a = (i_ctrl.alu_a == npc_pkg::A_PC) ? i_pc : i_rs1;

  always_comb begin
    case (i_ctrl.alu_b)
      npc_pkg::B_RS2: op_b = i_rs2;
      npc_pkg::B_IMM: op_b = i_imm;
      default:        op_b = 64'd4;
    endcase
  end

  always_comb begin
    case (i_ctrl.alu_op)
      npc_pkg::ALU_SUB:  alu_raw = op_a - op_b;
      npc_pkg::ALU_AND:  alu_raw = op_a & op_b;
      npc_pkg::ALU_OR:   alu_raw = op_a | op_b;
      npc_pkg::ALU_XOR:  alu_raw = op_a ^ op_b;
      npc_pkg::ALU_SLT:  alu_raw = {63'd0, $signed(op_a) < $signed(op_b)};
      npc_pkg::ALU_SLTU: alu_raw = {63'd0, op_a < op_b};
      npc_pkg::ALU_SLL:  alu_raw = op_a << op_b[5:0];
      npc_pkg::ALU_SRL:  alu_raw = op_a >> op_b[5:0];
      default:           alu_raw = op_a + op_b;
    endcase
  end

  // Word forms keep the low half, sign extended.
  assign o_alu_result = i_ctrl.word_cut ? {{32{alu_raw[31]}}, alu_raw[31:0]} : alu_raw;

  always_comb begin
    case (i_ctrl.branch)
      npc_pkg::BR_JAL:  taken = 1'b1;
      npc_pkg::BR_EQ:   taken = (i_rs1 == i_rs2);
      npc_pkg::BR_NE:   taken = (i_rs1 != i_rs2);
      npc_pkg::BR_LT:   taken = ($signed(i_rs1) < $signed(i_rs2));
      npc_pkg::BR_GE:   taken = ($signed(i_rs1) >= $signed(i_rs2));
      npc_pkg::BR_LTU:  taken = (i_rs1 < i_rs2);
      npc_pkg::BR_GEU:  taken = (i_rs1 >= i_rs2);
      default:          taken = 1'b0;
    endcase
  end

  assign jalr_target = (i_rs1 + i_imm) & ~64'd1;

  always_comb begin
    if (i_csr_redirect) begin
      o_nextpc = i_csr_target;  // Trap entry and return win.
    end else if (i_ctrl.branch == npc_pkg::BR_JALR) begin
      o_nextpc = jalr_target;
    end else if (taken) begin
      o_nextpc = i_pc + i_imm;
    end else begin
      o_nextpc = i_pc + 64'd4;
    end
  end

  always_comb begin
    case (i_ctrl.wb_sel)
      npc_pkg::WB_MEM: o_wb_data = i_load_data;
      npc_pkg::WB_CSR: o_wb_data = i_csr_rdata;
      default:         o_wb_data = o_alu_result;
    endcase
  end

  assign csr_src     = i_ctrl.sel_zimm ? i_zimm : i_rs1;
  assign o_csr_wdata = i_ctrl.csr_set ? (i_csr_rdata | csr_src) : csr_src;

endmodule

/* design/npc_lsu.sv */
// NPC load/store unit aligning store lanes and extending load data.
module npc_lsu (
  input  npc_pkg::ctrl_t i_ctrl,
  input  logic           i_halted,
  input  npc_pkg::xlen_t i_addr,
  input  npc_pkg::xlen_t i_wdata,
  input  npc_pkg::xlen_t i_dmem_rdata,
  output npc_pkg::xlen_t o_dmem_addr,
  output npc_pkg::xlen_t o_dmem_wdata,
  output logic [7:0]     o_dmem_be,
  output logic           o_dmem_wen,
  output npc_pkg::xlen_t o_load_data
);

  logic [2:0]     offset;
  logic [7:0]     size_mask;
  npc_pkg::xlen_t lane_data;
  npc_pkg::xlen_t ext_data;

  assign offset      = i_addr[2:0];
  assign o_dmem_addr = {i_addr[63:3], 3'b000};

  always_comb begin
    case (i_ctrl.mem_op)
      npc_pkg::MEM_B, npc_pkg::MEM_BU: size_mask = 8'h01;
      npc_pkg::MEM_W, npc_pkg::MEM_WU: size_mask = 8'h0f;
      default:                         size_mask = 8'hff;
    endcase
  end

  assign o_dmem_wdata = i_wdata << {offset, 3'b000};
  assign o_dmem_be    = i_ctrl.mem_wr ? (size_mask << offset) : 8'h00;
  assign o_dmem_wen   = i_ctrl.mem_wr && !i_halted;

  // Addressed byte moved down to lane 0.
  assign lane_data = i_dmem_rdata >> {offset, 3'b000};

  always_comb begin
    case (i_ctrl.mem_op)
      npc_pkg::MEM_B:  ext_data = {{56{lane_data[7]}}, lane_data[7:0]};
      npc_pkg::MEM_BU: ext_data = {56'd0, lane_data[7:0]};
      npc_pkg::MEM_W:  ext_data = {{32{lane_data[31]}}, lane_data[31:0]};
      npc_pkg::MEM_WU: ext_data = {32'd0, lane_data[31:0]};
      default:         ext_data = lane_data;
    endcase
  end

  assign o_load_data = i_ctrl.mem_rd ? ext_data : '0;

endmodule

/* design/npc_csr.sv */
// NPC machine CSR block with trap entry and return targets.
module npc_csr (
  input  logic               i_clk,
  input  logic               i_arst_n,
  input  npc_pkg::ctrl_t     i_ctrl,
  input  logic               i_halted,
  input  npc_pkg::csr_addr_t i_addr,
  input  npc_pkg::xlen_t     i_wdata,
  input  npc_pkg::xlen_t     i_pc,
  output npc_pkg::xlen_t     o_rdata,
  output logic               o_redirect,
  output npc_pkg::xlen_t     o_target
);

  npc_pkg::xlen_t mstatus;
  npc_pkg::xlen_t mtvec;
  npc_pkg::xlen_t mepc;
  npc_pkg::xlen_t mcause;

  always_comb begin
    case (i_addr)
      npc_pkg::CSR_MSTATUS: o_rdata = mstatus;
      npc_pkg::CSR_MTVEC:   o_rdata = mtvec;
      npc_pkg::CSR_MEPC:    o_rdata = mepc;
      npc_pkg::CSR_MCAUSE:  o_rdata = mcause;
      default:              o_rdata = '0;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (!i_halted) begin
      if (i_ctrl.ecall) begin
        mepc   <= i_pc;
        mcause <= npc_pkg::CAUSE_ECALL_M;
      end else if (i_ctrl.csr_wr) begin
        case (i_addr)
          npc_pkg::CSR_MSTATUS: mstatus <= i_wdata;
          npc_pkg::CSR_MTVEC:   mtvec   <= i_wdata;
          npc_pkg::CSR_MEPC:    mepc    <= i_wdata;
          npc_pkg::CSR_MCAUSE:  mcause  <= i_wdata;
          default: ;  // Unmapped, dropped.
        endcase
      end
    end
  end

  assign o_redirect = i_ctrl.ecall || i_ctrl.mret;
  assign o_target   = i_ctrl.mret ? mepc : mtvec;

endmodule

/* design/npc_core.sv */
// NPC single-cycle RV64 core top connecting fetch, decode, execute, LSU and CSRs.
module npc_core (
  input  logic           i_clk,
  input  logic           i_arst_n,
  output npc_pkg::xlen_t o_imem_addr,
  input  npc_pkg::inst_t i_imem_data,
  output npc_pkg::xlen_t o_dmem_addr,
  input  npc_pkg::xlen_t i_dmem_rdata,
  output npc_pkg::xlen_t o_dmem_wdata,
  output logic [7:0]     o_dmem_be,
  output logic           o_dmem_wen,
  output logic           o_halt,
  output npc_pkg::xlen_t o_pc
);

  npc_pkg::xlen_t     pc, nextpc;
  logic               halted;
  npc_pkg::ctrl_t     ctrl;
  npc_pkg::xlen_t     rs1data, rs2data, imm, zimm;
  npc_pkg::csr_addr_t csr_addr;
  npc_pkg::xlen_t     alu_result, wb_data, csr_wdata, load_data;
  npc_pkg::xlen_t     csr_rdata, csr_target;
  logic               csr_redirect;

  npc_ifu u_ifu (
    .i_clk(i_clk), .i_arst_n(i_arst_n),
    .i_nextpc(nextpc), .i_stop(ctrl.invalid),
    .o_pc(pc), .o_halted(halted)
  );

  npc_idu u_idu (
    .i_clk(i_clk), .i_arst_n(i_arst_n),
    .i_inst(i_imem_data), .i_halted(halted), .i_wb_data(wb_data),
    .o_ctrl(ctrl), .o_rs1data(rs1data), .o_rs2data(rs2data),
    .o_imm(imm), .o_zimm(zimm), .o_csr_addr(csr_addr)
  );

  npc_exu u_exu (
    .i_ctrl(ctrl), .i_pc(pc), .i_rs1(rs1data), .i_rs2(rs2data),
    .i_imm(imm), .i_zimm(zimm), .i_load_data(load_data),
    .i_csr_rdata(csr_rdata), .i_csr_redirect(csr_redirect), .i_csr_target(csr_target),
    .o_alu_result(alu_result), .o_nextpc(nextpc),
    .o_wb_data(wb_data), .o_csr_wdata(csr_wdata)
  );

  npc_lsu u_lsu (
    .i_ctrl(ctrl), .i_halted(halted),
    .i_addr(alu_result), .i_wdata(rs2data), .i_dmem_rdata(i_dmem_rdata),
    .o_dmem_addr(o_dmem_addr), .o_dmem_wdata(o_dmem_wdata),
    .o_dmem_be(o_dmem_be), .o_dmem_wen(o_dmem_wen), .o_load_data(load_data)
  );

  npc_csr u_csr (
    .i_clk(i_clk), .i_arst_n(i_arst_n),
    .i_ctrl(ctrl), .i_halted(halted), .i_addr(csr_addr),
    .i_wdata(csr_wdata), .i_pc(pc),
    .o_rdata(csr_rdata), .o_redirect(csr_redirect), .o_target(csr_target)
  );

  assign o_imem_addr = pc;
  assign o_pc        = pc;
  assign o_halt      = halted;

endmodule

/* dv/npc_tb_mem.sv */
// Testbench memory model serving the NPC instruction and data ports from one array.
module npc_tb_mem (
  input  logic           i_clk,
  input  npc_pkg::xlen_t i_imem_addr,
  output npc_pkg::inst_t o_imem_data,
  input  npc_pkg::xlen_t i_dmem_addr,
  output npc_pkg::xlen_t o_dmem_rdata,
  input  npc_pkg::xlen_t i_dmem_wdata,
  input  logic [7:0]     i_dmem_be,
  input  logic           i_dmem_wen,
  input  logic           i_load_en,
  input  logic [8:0]     i_load_idx,
  input  npc_pkg::xlen_t i_load_data
);

  npc_pkg::xlen_t mem [0:511];  // 4 KiB, low address bits only.
  npc_pkg::xlen_t iword;

  assign iword        = mem[i_imem_addr[11:3]];
  assign o_imem_data  = i_imem_addr[2] ? iword[63:32] : iword[31:0];
  assign o_dmem_rdata = mem[i_dmem_addr[11:3]];

  always_ff @(posedge i_clk) begin
    if (i_load_en) begin
      mem[i_load_idx] <= i_load_data;  // Program loading wins.
    end else if (i_dmem_wen) begin
      for (int b = 0; b < 8; b++) begin
        if (i_dmem_be[b]) begin
          mem[i_dmem_addr[11:3]][8*b +: 8] <= i_dmem_wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

/* dv/npc_tb.sv */
// Testbench for the NPC core running directed programs from a shared memory model.
module npc_tb;

  localparam int NUM_TESTS = 6;
  localparam int RUN_LIMIT = 200;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * (512 + 16 + RUN_LIMIT);

  logic           i_clk;
  logic           i_arst_n;
  npc_pkg::xlen_t imem_addr, dmem_addr, dmem_rdata, dmem_wdata, pc, load_data;
  npc_pkg::inst_t imem_data;
  logic [7:0]     dmem_be;
  logic           dmem_wen, halt, load_en;
  logic [8:0]     load_idx;
  npc_pkg::inst_t prog[$];
  npc_pkg::xlen_t expv[$];
  int             errors, checks, test_errors;

  npc_core UUT (
    .i_clk(i_clk), .i_arst_n(i_arst_n),
    .o_imem_addr(imem_addr), .i_imem_data(imem_data),
    .o_dmem_addr(dmem_addr), .i_dmem_rdata(dmem_rdata), .o_dmem_wdata(dmem_wdata),
    .o_dmem_be(dmem_be), .o_dmem_wen(dmem_wen), .o_halt(halt), .o_pc(pc)
  );

  npc_tb_mem u_mem (
    .i_clk(i_clk), .i_imem_addr(imem_addr), .o_imem_data(imem_data),
    .i_dmem_addr(dmem_addr), .o_dmem_rdata(dmem_rdata), .i_dmem_wdata(dmem_wdata),
    .i_dmem_be(dmem_be), .i_dmem_wen(dmem_wen),
    .i_load_en(load_en), .i_load_idx(load_idx), .i_load_data(load_data)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * 100);
    $display("Watchdog expired before the tests completed.");
    $display("Simulation finished: FAIL");
    $finish;
  end

  function automatic npc_pkg::inst_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic npc_pkg::inst_t enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [6:0] op);
    return {f7, rs2, rs1, f3, 5'd3, op};  // Results always go to x3.
  endfunction

  function automatic npc_pkg::inst_t enc_s(logic [11:0] imm, logic [4:0] rs2, logic [2:0] f3);
    return {imm[11:5], rs2, 5'd31, f3, imm[4:0], npc_pkg::OP_STORE};  // Base x31.
  endfunction

  function automatic npc_pkg::inst_t enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], npc_pkg::OP_BRANCH};
  endfunction

  function automatic npc_pkg::inst_t enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, npc_pkg::OP_JAL};
  endfunction

  function automatic npc_pkg::xlen_t sext32(logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  function automatic npc_pkg::xlen_t pc_of(int idx);
    return npc_pkg::RESET_PC + 64'(idx) * 4;
  endfunction

  function automatic npc_pkg::xlen_t fill_word(int idx);
    npc_pkg::xlen_t a;
    a = npc_pkg::RESET_PC + 64'(idx) * 8;
    return a ^ {a[31:0], a[63:32]} ^ 64'h3c5a_96c3_0f1e_e1f0;
  endfunction

  // Data slots start at RESET_PC + 0x400 in word 128.
  function automatic npc_pkg::xlen_t peek(int slot);
    return u_mem.mem[128 + slot];
  endfunction

  task automatic check_eq(string sig, npc_pkg::xlen_t got, npc_pkg::xlen_t exp);
    checks++;
    assert (got === exp) else begin
      $display("FAIL %s got %h expected %h", sig, got, exp);
      errors++;
    end
  endtask

  task automatic start_prog();
    prog.delete();
    expv.delete();
    prog.push_back({20'd0, 5'd31, npc_pkg::OP_AUIPC});
    prog.push_back(enc_i(12'h400, 31, 3'd0, 31, npc_pkg::OP_IMM));
  endtask

  // Builds a 64-bit value byte by byte with addi, slli and ori.
  task automatic add_const(logic [4:0] rd, npc_pkg::xlen_t v);
    prog.push_back(enc_i({4'd0, v[63:56]}, 0, 3'd0, rd, npc_pkg::OP_IMM));
    for (int k = 6; k >= 0; k--) begin
      prog.push_back(enc_i(12'd8, rd, 3'd1, rd, npc_pkg::OP_IMM));
      prog.push_back(enc_i({4'd0, v[8*k +: 8]}, rd, 3'd6, rd, npc_pkg::OP_IMM));
    end
  endtask

  task automatic result_op(npc_pkg::inst_t inst, npc_pkg::xlen_t exp);
    prog.push_back(inst);
    prog.push_back(enc_s(12'(expv.size() * 8), 3, 3'd3));
    expv.push_back(exp);
  endtask

  task automatic load_memory();
    npc_pkg::xlen_t w;
    for (int k = 0; k < 512; k++) begin
      if (k < 128) begin
        w[31:0]  = (2*k < prog.size()) ? prog[2*k] : 32'd0;
        w[63:32] = (2*k + 1 < prog.size()) ? prog[2*k + 1] : 32'd0;
      end else begin
        w = fill_word(k);
      end
      @(posedge i_clk);
      load_en   <= 1'b1;
      load_idx  <= 9'(k);
      load_data <= w;
    end
    @(posedge i_clk);
    load_en <= 1'b0;
  endtask

  task automatic reset_core();
    @(posedge i_clk);
    i_arst_n <= 1'b0;
    repeat (4) begin
      @(negedge i_clk);
      check_eq("o_pc", pc, npc_pkg::RESET_PC);
      check_eq("o_halt", 64'(halt), 64'd0);
    end
    @(posedge i_clk);
    i_arst_n <= 1'b1;
  endtask

  task automatic run_prog();
    int n;
    load_memory();
    reset_core();
    n = 0;
    @(negedge i_clk);
    while (!halt && n < RUN_LIMIT) begin
      @(negedge i_clk);
      n++;
    end
    checks++;
    assert (halt) else begin
      $display("Core did not halt within %0d cycles.", RUN_LIMIT);
      errors++;
    end
  endtask

  task automatic check_slots();
    for (int i = 0; i < expv.size(); i++) begin
      check_eq($sformatf("dmem slot %0d", i), peek(i), expv[i]);
    end
  endtask

  task automatic report(string name);
    $display("test %-8s %s (%0d errors)", name, (errors == test_errors) ? "ok" : "bad",
             errors - test_errors);
    test_errors = errors;
  endtask

  task automatic test_reset();
    prog.delete();
    prog.push_back(32'h0010_0073);  // Ebreak at the reset vector.
    load_memory();
    reset_core();
    @(negedge i_clk);
    check_eq("o_pc", pc, npc_pkg::RESET_PC);
    check_eq("o_halt", 64'(halt), 64'd0);
    report("reset");
  endtask

  task automatic test_arith();
    npc_pkg::xlen_t a, b, ie;
    logic [11:0]    imm;
    logic [5:0]     sh;
    logic [19:0]    u;
    a   = {$urandom, $urandom};
    b   = {$urandom, $urandom};
    imm = 12'($urandom);
    sh  = 6'($urandom);
    u   = 20'($urandom);
    ie  = {{52{imm[11]}}, imm};
    start_prog();
    add_const(1, a);
    add_const(2, b);
    result_op(enc_r(7'h00, 2, 1, 3'd0, npc_pkg::OP_OP), a + b);
    result_op(enc_r(7'h20, 2, 1, 3'd0, npc_pkg::OP_OP), a - b);
    result_op(enc_r(7'h00, 2, 1, 3'd7, npc_pkg::OP_OP), a & b);
    result_op(enc_r(7'h00, 2, 1, 3'd6, npc_pkg::OP_OP), a | b);
    result_op(enc_r(7'h00, 2, 1, 3'd4, npc_pkg::OP_OP), a ^ b);
    result_op(enc_r(7'h00, 2, 1, 3'd2, npc_pkg::OP_OP), 64'($signed(a) < $signed(b)));
    result_op(enc_r(7'h00, 2, 1, 3'd3, npc_pkg::OP_OP), 64'(a < b));
    result_op(enc_r(7'h00, 2, 1, 3'd1, npc_pkg::OP_OP), a << b[5:0]);
    result_op(enc_r(7'h00, 2, 1, 3'd5, npc_pkg::OP_OP), a >> b[5:0]);
    result_op(enc_i(imm, 1, 3'd0, 3, npc_pkg::OP_IMM), a + ie);
    result_op(enc_i(imm, 1, 3'd2, 3, npc_pkg::OP_IMM), 64'($signed(a) < $signed(ie)));
    result_op(enc_i(imm, 1, 3'd4, 3, npc_pkg::OP_IMM), a ^ ie);
    result_op(enc_i(imm, 1, 3'd6, 3, npc_pkg::OP_IMM), a | ie);
    result_op(enc_i(imm, 1, 3'd7, 3, npc_pkg::OP_IMM), a & ie);
    result_op(enc_i({6'd0, sh}, 1, 3'd1, 3, npc_pkg::OP_IMM), a << sh);
    result_op(enc_i({6'd0, sh}, 1, 3'd5, 3, npc_pkg::OP_IMM), a >> sh);
    result_op(enc_i(imm, 1, 3'd0, 3, npc_pkg::OP_IMM32), sext32(a[31:0] + ie[31:0]));
    result_op(enc_r(7'h00, 2, 1, 3'd0, npc_pkg::OP_OP32), sext32(a[31:0] + b[31:0]));
    result_op(enc_r(7'h20, 2, 1, 3'd0, npc_pkg::OP_OP32), sext32(a[31:0] - b[31:0]));
    result_op({u, 5'd3, npc_pkg::OP_LUI}, sext32({u, 12'd0}));
    result_op({u, 5'd3, npc_pkg::OP_AUIPC}, pc_of(prog.size()) + sext32({u, 12'd0}));
    prog.push_back(32'h0010_0073);
    run_prog();
    check_slots();
    report("arith");
  endtask

  // Taken path stores 0x100 + slot and fall-through stores 0x200 + slot.
  task automatic branch_case(logic [2:0] f3, logic [4:0] r1, logic [4:0] r2, bit taken);
    int slot;
    slot = expv.size();
    prog.push_back(enc_b(13'd12, r2, r1, f3));
    prog.push_back(enc_i(12'(32'h200 + slot), 0, 3'd0, 3, npc_pkg::OP_IMM));
    prog.push_back(enc_j(21'd8, 0));
    prog.push_back(enc_i(12'(32'h100 + slot), 0, 3'd0, 3, npc_pkg::OP_IMM));
    prog.push_back(enc_s(12'(slot * 8), 3, 3'd3));
    expv.push_back(taken ? 64'(32'h100 + slot) : 64'(32'h200 + slot));
  endtask

  task automatic test_branch();
    int p;
    start_prog();
    prog.push_back(enc_i(12'hffb, 0, 3'd0, 1, npc_pkg::OP_IMM));  // x1 = -5.
    prog.push_back(enc_i(12'd3, 0, 3'd0, 2, npc_pkg::OP_IMM));
    branch_case(3'd0, 1, 1, 1'b1);
    branch_case(3'd0, 1, 2, 1'b0);
    branch_case(3'd1, 1, 2, 1'b1);
    branch_case(3'd1, 1, 1, 1'b0);
    branch_case(3'd4, 1, 2, 1'b1);
    branch_case(3'd4, 2, 1, 1'b0);
    branch_case(3'd5, 2, 1, 1'b1);
    branch_case(3'd5, 1, 2, 1'b0);
    branch_case(3'd6, 2, 1, 1'b1);
    branch_case(3'd6, 1, 2, 1'b0);
    branch_case(3'd7, 1, 2, 1'b1);
    branch_case(3'd7, 2, 1, 1'b0);
    p = prog.size();
    prog.push_back(enc_j(21'd8, 5));
    prog.push_back(32'h0010_0073);  // Skipped.
    result_op(enc_i(12'd0, 5, 3'd0, 3, npc_pkg::OP_IMM), pc_of(p) + 4);
    p = prog.size();
    prog.push_back({20'd0, 5'd6, npc_pkg::OP_AUIPC});
    prog.push_back(enc_i(12'd13, 6, 3'd0, 7, npc_pkg::OP_JALR));  // Bit 0 dropped.
    prog.push_back(32'h0010_0073);
    result_op(enc_i(12'd0, 7, 3'd0, 3, npc_pkg::OP_IMM), pc_of(p + 1) + 4);
    prog.push_back(32'h0010_0073);
    run_prog();
    check_slots();
    report("branch");
  endtask

  task automatic test_mem();
    npc_pkg::xlen_t a;
    a = {$urandom, $urandom};
    start_prog();
    add_const(1, a);
    prog.push_back(enc_s(12'd0, 1, 3'd3));
    for (int o = 0; o < 8; o++) begin
      prog.push_back(enc_i(12'(8 * o), 1, 3'd5, 2, npc_pkg::OP_IMM));
      prog.push_back(enc_s(12'(8 + o), 2, 3'd0));
    end
    prog.push_back(enc_s(12'd16, 1, 3'd2));
    prog.push_back(enc_i(12'd32, 1, 3'd5, 2, npc_pkg::OP_IMM));
    prog.push_back(enc_s(12'd20, 2, 3'd2));
    repeat (3) expv.push_back(a);
    for (int o = 0; o < 8; o++) begin
      result_op(enc_i(12'(8 + o), 31, 3'd0, 3, npc_pkg::OP_LOAD), {{56{a[8*o+7]}}, a[8*o +: 8]});
    end
    for (int o = 0; o < 8; o++) begin
      result_op(enc_i(12'(8 + o), 31, 3'd4, 3, npc_pkg::OP_LOAD), {56'd0, a[8*o +: 8]});
    end
    for (int h = 0; h < 2; h++) begin
      result_op(enc_i(12'(16 + 4 * h), 31, 3'd2, 3, npc_pkg::OP_LOAD), sext32(a[32*h +: 32]));
    end
    for (int h = 0; h < 2; h++) begin
      result_op(enc_i(12'(16 + 4 * h), 31, 3'd6, 3, npc_pkg::OP_LOAD), {32'd0, a[32*h +: 32]});
    end
    result_op(enc_i(12'd0, 31, 3'd3, 3, npc_pkg::OP_LOAD), a);
    prog.push_back(32'h0010_0073);
    run_prog();
    check_slots();
    report("mem");
  endtask

  task automatic test_csr();
    start_prog();
    prog.push_back({20'd0, 5'd1, npc_pkg::OP_AUIPC});
    prog.push_back(enc_i(12'd44, 1, 3'd0, 1, npc_pkg::OP_IMM));          // Handler at 13.
    prog.push_back(enc_i(npc_pkg::CSR_MTVEC, 1, 3'd1, 0, npc_pkg::OP_SYSTEM));
    prog.push_back(enc_i(npc_pkg::CSR_MSTATUS, 9, 3'd5, 4, npc_pkg::OP_SYSTEM));
    prog.push_back(enc_i(npc_pkg::CSR_MSTATUS, 0, 3'd2, 5, npc_pkg::OP_SYSTEM));
    prog.push_back(enc_s(12'd16, 5, 3'd3));
    prog.push_back(32'h0000_0073);                                       // Ecall at 8.
    prog.push_back(32'h0010_0073);
    prog.push_back(enc_i(12'h055, 0, 3'd0, 3, npc_pkg::OP_IMM));         // Continuation.
    prog.push_back(enc_s(12'd24, 3, 3'd3));
    prog.push_back(32'h0010_0073);
    prog.push_back(enc_i(npc_pkg::CSR_MEPC, 0, 3'd2, 10, npc_pkg::OP_SYSTEM));
    prog.push_back(enc_s(12'd0, 10, 3'd3));
    prog.push_back(enc_i(npc_pkg::CSR_MCAUSE, 0, 3'd2, 11, npc_pkg::OP_SYSTEM));
    prog.push_back(enc_s(12'd8, 11, 3'd3));
    prog.push_back({20'd0, 5'd12, npc_pkg::OP_AUIPC});
    prog.push_back(enc_i(12'hfe4, 12, 3'd0, 12, npc_pkg::OP_IMM));       // Back by 28.
    prog.push_back(enc_i(npc_pkg::CSR_MEPC, 12, 3'd1, 0, npc_pkg::OP_SYSTEM));
    prog.push_back(32'h3020_0073);
    expv.push_back(pc_of(8));
    expv.push_back(64'd11);
    expv.push_back(64'd9);
    expv.push_back(64'h55);
    run_prog();
    check_slots();
    check_eq("o_pc", pc, pc_of(12));
    report("csr");
  endtask

  task automatic test_halt();
    start_prog();
    prog.push_back(enc_i(12'h077, 0, 3'd0, 3, npc_pkg::OP_IMM));
    prog.push_back(enc_s(12'd0, 3, 3'd3));
    prog.push_back(32'hffff_ffff);
    prog.push_back(enc_s(12'd8, 3, 3'd3));
    prog.push_back(32'h0010_0073);
    run_prog();
    repeat (3) @(negedge i_clk);
    check_eq("o_pc", pc, pc_of(4));
    check_eq("o_halt", 64'(halt), 64'd1);
    check_eq("dmem slot 0", peek(0), 64'h77);
    check_eq("dmem slot 1", peek(1), fill_word(129));
    report("halt");
  endtask

  initial begin
    i_arst_n    = 1'b0;
    load_en     = 1'b0;
    load_idx    = '0;
    load_data   = '0;
    errors      = 0;
    checks      = 0;
    test_errors = 0;
    void'($urandom(32'hf7f9));
    test_reset();
    test_arith();
    test_branch();
    test_mem();
    test_csr();
    test_halt();
    $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* all.f */
design/npc_pkg.sv
design/npc_ifu.sv
design/npc_idu.sv
design/npc_exu.sv
design/npc_lsu.sv
design/npc_csr.sv
design/npc_core.sv
dv/npc_tb_mem.sv
dv/npc_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= npc_tb
FILELIST  ?= all.f
LOG       ?= sim.log
PASS_MSG  := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
